//--- Bender.yml
package:
  name: read_guard

sources:
  - hw/guard_axi_pkg.sv
  - hw/guard_reg_pkg.sv
  - hw/guard_txn_table.sv
  - hw/guard_budget_timer.sv
  - hw/guard_ctrl_fsm.sv
  - hw/guard_cfg_regs.sv
  - hw/read_guard_top.sv
  - target: test
    files:
      - test/read_guard_assert.sv
      - test/tb_read_guard.sv

//--- hw/guard_axi_pkg.sv
// Widths and response codes of the guarded AXI read channel
// One table entry exists per ID, so NumIds follows IdWidth directly
`default_nettype none

package guard_axi_pkg;

  // Four IDs keep the outstanding table small
  localparam int unsigned IdWidth   = 2;
  localparam int unsigned NumIds    = 2 ** IdWidth;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned LenWidth  = 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [LenWidth-1:0]  len_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

endpackage

`default_nettype wire

//--- hw/guard_budget_timer.sv
// Wall-clock cycle counters, one per table entry, stalls included
// Counters saturate at all ones and restart on the entry's start pulse
`default_nettype none

module guard_budget_timer (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [guard_axi_pkg::NumIds-1:0]   start_i,
  input  logic [guard_axi_pkg::NumIds-1:0]   busy_i,
  input  logic [guard_reg_pkg::CntWidth-1:0] budget_i,
  output logic [guard_axi_pkg::NumIds-1:0]   expire_o
);
  import guard_axi_pkg::*;
  import guard_reg_pkg::*;

  logic [CntWidth-1:0] cnt_q [NumIds];

  for (genvar i = 0; i < NumIds; i++) begin : gen_cnt

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (start_i[i]) begin
        cnt_q[i] <= '0;
      end else if (busy_i[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end

    // Stays high until the burst ends or the table is flushed
    assign expire_o[i] = busy_i[i] & (cnt_q[i] >= budget_i);

  end

endmodule

`default_nettype wire

//--- hw/guard_cfg_regs.sv
// Register bank; reads are combinational and ready echoes valid
// Status and captured address are read-only, writes to them flag an error
// A control write with the clear bit gives a single-cycle clear pulse
`default_nettype none

module guard_cfg_regs (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  guard_reg_pkg::reg_addr_t           reg_addr_i,
  input  logic                               reg_write_i,
  input  guard_reg_pkg::reg_data_t           reg_wdata_i,
  input  logic                               reg_valid_i,
  output guard_reg_pkg::reg_data_t           reg_rdata_o,
  output logic                               reg_error_o,
  output logic                               reg_ready_o,
  input  logic                               trip_i,
  input  guard_axi_pkg::id_t                 trip_id_i,
  input  logic                               tripped_i,
  input  guard_axi_pkg::addr_t               query_addr_i,
  output guard_axi_pkg::id_t                 query_id_o,
  output logic                               enable_o,
  output logic                               rst_on_timeout_o,
  output logic                               clear_o,
  output logic [guard_reg_pkg::CntWidth-1:0] budget_o
);
  import guard_axi_pkg::*;
  import guard_reg_pkg::*;

  reg_word_u           wword;
  reg_word_u           rword;
  logic                mapped;
  logic                ro_hit;
  logic                wr_ok;
  logic                enable_q;
  logic                rst_on_timeout_q;
  logic [CntWidth-1:0] budget_q;
  id_t                 trip_id_q;

  assign wword.raw = reg_wdata_i;

  always_comb begin
    mapped    = 1'b1;
    rword.raw = '0;
    case (reg_addr_i)
      RegCtrl: begin
        rword.ctrl.enable         = enable_q;
        rword.ctrl.rst_on_timeout = rst_on_timeout_q;
      end
      RegBudget: rword.budget.value = budget_q;
      RegStatus: begin
        rword.status.tripped      = tripped_i;
        rword.status.offending_id = trip_id_q;
      end
      RegAddr: rword.raw = query_addr_i;
      default: mapped = 1'b0;
    endcase
  end

  assign ro_hit      = (reg_addr_i == RegStatus) | (reg_addr_i == RegAddr);
  assign reg_error_o = reg_valid_i & (~mapped | (reg_write_i & ro_hit));
  assign reg_ready_o = reg_valid_i;
  assign reg_rdata_o = rword.raw;

  assign wr_ok   = reg_valid_i & reg_write_i & ~reg_error_o;
  assign clear_o = wr_ok & (reg_addr_i == RegCtrl) & wword.ctrl.clear;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q         <= 1'b0;
      rst_on_timeout_q <= 1'b0;
      budget_q         <= BudgetReset;
      trip_id_q        <= '0;
    end else begin
      if (wr_ok && (reg_addr_i == RegCtrl)) begin
        enable_q         <= wword.ctrl.enable;
        rst_on_timeout_q <= wword.ctrl.rst_on_timeout;
      end
      if (wr_ok && (reg_addr_i == RegBudget)) begin
        budget_q <= wword.budget.value;
      end
      if (trip_i) trip_id_q <= trip_id_i;
    end
  end

  // Latched ID also selects the address shown at RegAddr
  assign query_id_o       = trip_id_q;
  assign enable_o         = enable_q;
  assign rst_on_timeout_o = rst_on_timeout_q;
  assign budget_o         = budget_q;

endmodule

`default_nettype wire

//--- hw/guard_ctrl_fsm.sv
// Guard modes: bypass when disabled, monitor when enabled, tripped on a timeout
// irq_o and rst_req_o are registered and follow the tripped state
// With several expiring IDs the lowest one is reported
`default_nettype none

module guard_ctrl_fsm (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             enable_i,
  input  logic                             rst_on_timeout_i,
  input  logic                             clear_i,
  input  logic [guard_axi_pkg::NumIds-1:0] expire_i,
  output logic                             track_o,
  output logic                             block_o,
  output logic                             flush_o,
  output logic                             trip_o,
  output guard_axi_pkg::id_t               trip_id_o,
  output logic                             irq_o,
  output logic                             rst_req_o
);
  import guard_axi_pkg::*;

  typedef enum logic [1:0] {
    BYPASS,
    MONITOR,
    TRIPPED
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    trip_id_o = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (expire_i[i]) begin
        trip_id_o = id_t'(i);
      end
    end
  end

  assign trip_o  = (state_q == MONITOR) & enable_i & (|expire_i);
  assign track_o = (state_q != BYPASS);
  assign block_o = (state_q == TRIPPED);
  assign flush_o = track_o & (~enable_i | (block_o & clear_i));

  always_comb begin
    state_d = state_q;
    case (state_q)
      BYPASS:  if (enable_i) state_d = MONITOR;
      MONITOR: begin
        if (!enable_i) state_d = BYPASS;
        else if (|expire_i) state_d = TRIPPED;
      end
      TRIPPED: begin
        if (!enable_i) state_d = BYPASS;
        else if (clear_i) state_d = MONITOR;
      end
      default: state_d = BYPASS;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= BYPASS;
      irq_o     <= 1'b0;
      rst_req_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      irq_o     <= (state_d == TRIPPED);
      rst_req_o <= (state_d == TRIPPED) & rst_on_timeout_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/guard_reg_pkg.sv
// Register map of the read guard, word offsets on a 32-bit bus
// Writes are whole-word, there are no byte strobes
// The clear bit of the control word reads back as zero
`default_nettype none

package guard_reg_pkg;

  localparam int unsigned RegAddrWidth = 32;
  localparam int unsigned RegDataWidth = 32;

  typedef logic [RegAddrWidth-1:0] reg_addr_t;
  typedef logic [RegDataWidth-1:0] reg_data_t;

  localparam reg_addr_t RegCtrl   = 32'h0;
  localparam reg_addr_t RegBudget = 32'h4;
  localparam reg_addr_t RegStatus = 32'h8;
  localparam reg_addr_t RegAddr   = 32'hC;

  // Budget and per-ID counters share this width
  localparam int unsigned CntWidth = 16;
  localparam logic [CntWidth-1:0] BudgetReset = CntWidth'(64);

  typedef struct packed {
    logic [RegDataWidth-4:0] reserved;
    logic                    clear;
    logic                    rst_on_timeout;
    logic                    enable;
  } ctrl_fields_t;

  typedef struct packed {
    logic [RegDataWidth-7:0] zero_hi;
    logic [1:0]              offending_id;
    logic [2:0]              zero_lo;
    logic                    tripped;
  } status_fields_t;

  typedef struct packed {
    logic [RegDataWidth-CntWidth-1:0] pad;
    logic [CntWidth-1:0]              value;
  } budget_fields_t;

  // One bus word, decoded according to the offset
  typedef union packed {
    ctrl_fields_t   ctrl;
    status_fields_t status;
    budget_fields_t budget;
    reg_data_t      raw;
  } reg_word_u;

endpackage

`default_nettype wire

//--- hw/guard_txn_table.sv
// One outstanding burst per ID; a second AR on a busy ID stalls while tracking
// Forwarding of AR valid and ready is decided here only
// Entries are only set while tracking, flush_i empties the table
`default_nettype none

module guard_txn_table (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  guard_axi_pkg::id_t               ar_id_i,
  input  guard_axi_pkg::addr_t             ar_addr_i,
  input  logic                             mgr_ar_valid_i,
  input  logic                             sub_ar_ready_i,
  input  guard_axi_pkg::id_t               r_id_i,
  input  logic                             r_last_i,
  input  logic                             r_valid_i,
  input  logic                             r_ready_i,
  input  logic                             track_i,
  input  logic                             block_i,
  input  logic                             flush_i,
  input  guard_axi_pkg::id_t               query_id_i,
  output logic                             ar_valid_o,
  output logic                             ar_ready_o,
  output logic [guard_axi_pkg::NumIds-1:0] busy_o,
  output logic [guard_axi_pkg::NumIds-1:0] start_o,
  output guard_axi_pkg::addr_t             query_addr_o
);
  import guard_axi_pkg::*;

  logic [NumIds-1:0] busy_q;
  logic [NumIds-1:0] done;
  addr_t             addr_q [NumIds];
  logic              fwd_en;
  logic              ar_hs;
  logic              r_done;

  // Busy IDs only hold back new ARs while tracking
  assign fwd_en = ~block_i & (~track_i | ~busy_q[ar_id_i]);

  assign ar_valid_o = mgr_ar_valid_i & fwd_en;
  assign ar_ready_o = sub_ar_ready_i & fwd_en;
  assign ar_hs      = mgr_ar_valid_i & sub_ar_ready_i & fwd_en;
  assign r_done     = r_valid_i & r_ready_i & r_last_i;

  always_comb begin
    start_o = '0;
    done    = '0;
    start_o[ar_id_i] = ar_hs & track_i;
    done[r_id_i]     = r_done;
  end

  // A burst ending this cycle no longer counts as busy
  assign busy_o = busy_q & ~done;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~done) | start_o;
    end
  end

  // Captured burst addresses for the status readout
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumIds; i++) begin
      if (start_o[i]) begin
        addr_q[i] <= ar_addr_i;
      end
    end
  end

  assign query_addr_o = addr_q[query_id_i];

endmodule

`default_nettype wire

//--- hw/read_guard_top.sv
// Read-path guard between a manager and a subordinate, AR and R channels only
// The R channel and AR payload pass through unchanged, AR handshake is gated
// irq_o stays high until software writes clear or drops enable
`default_nettype none

module read_guard_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Manager side
  input  guard_axi_pkg::id_t       mgr_ar_id_i,
  input  guard_axi_pkg::addr_t     mgr_ar_addr_i,
  input  guard_axi_pkg::len_t      mgr_ar_len_i,
  input  logic                     mgr_ar_valid_i,
  output logic                     mgr_ar_ready_o,
  output guard_axi_pkg::id_t       mgr_r_id_o,
  output guard_axi_pkg::data_t     mgr_r_data_o,
  output guard_axi_pkg::resp_t     mgr_r_resp_o,
  output logic                     mgr_r_last_o,
  output logic                     mgr_r_valid_o,
  input  logic                     mgr_r_ready_i,
  // Subordinate side
  output guard_axi_pkg::id_t       sub_ar_id_o,
  output guard_axi_pkg::addr_t     sub_ar_addr_o,
  output guard_axi_pkg::len_t      sub_ar_len_o,
  output logic                     sub_ar_valid_o,
  input  logic                     sub_ar_ready_i,
  input  guard_axi_pkg::id_t       sub_r_id_i,
  input  guard_axi_pkg::data_t     sub_r_data_i,
  input  guard_axi_pkg::resp_t     sub_r_resp_i,
  input  logic                     sub_r_last_i,
  input  logic                     sub_r_valid_i,
  output logic                     sub_r_ready_o,
  // Register bus
  input  guard_reg_pkg::reg_addr_t reg_addr_i,
  input  logic                     reg_write_i,
  input  guard_reg_pkg::reg_data_t reg_wdata_i,
  input  logic                     reg_valid_i,
  output guard_reg_pkg::reg_data_t reg_rdata_o,
  output logic                     reg_error_o,
  output logic                     reg_ready_o,
  output logic                     irq_o,
  output logic                     rst_req_o
);
  import guard_axi_pkg::*;
  import guard_reg_pkg::*;

  logic [NumIds-1:0]   busy;
  logic [NumIds-1:0]   start;
  logic [NumIds-1:0]   expire;
  logic                track;
  logic                block;
  logic                flush;
  logic                trip;
  id_t                 trip_id;
  id_t                 query_id;
  addr_t               query_addr;
  logic                enable;
  logic                rst_on_timeout;
  logic                clear;
  logic [CntWidth-1:0] budget;

  assign sub_ar_id_o   = mgr_ar_id_i;
  assign sub_ar_addr_o = mgr_ar_addr_i;
  assign sub_ar_len_o  = mgr_ar_len_i;

  assign mgr_r_id_o    = sub_r_id_i;
  assign mgr_r_data_o  = sub_r_data_i;
  assign mgr_r_resp_o  = sub_r_resp_i;
  assign mgr_r_last_o  = sub_r_last_i;
  assign mgr_r_valid_o = sub_r_valid_i;
  assign sub_r_ready_o = mgr_r_ready_i;

  guard_txn_table i_txn_table (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ar_id_i        ( mgr_ar_id_i    ),
    .ar_addr_i      ( mgr_ar_addr_i  ),
    .mgr_ar_valid_i ( mgr_ar_valid_i ),
    .sub_ar_ready_i ( sub_ar_ready_i ),
    .r_id_i         ( sub_r_id_i     ),
    .r_last_i       ( sub_r_last_i   ),
    .r_valid_i      ( sub_r_valid_i  ),
    .r_ready_i      ( mgr_r_ready_i  ),
    .track_i        ( track          ),
    .block_i        ( block          ),
    .flush_i        ( flush          ),
    .query_id_i     ( query_id       ),
    .ar_valid_o     ( sub_ar_valid_o ),
    .ar_ready_o     ( mgr_ar_ready_o ),
    .busy_o         ( busy           ),
    .start_o        ( start          ),
    .query_addr_o   ( query_addr     )
  );

  guard_budget_timer i_budget_timer (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .start_i  ( start   ),
    .busy_i   ( busy    ),
    .budget_i ( budget  ),
    .expire_o ( expire  )
  );

  guard_ctrl_fsm i_ctrl_fsm (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .enable_i         ( enable         ),
    .rst_on_timeout_i ( rst_on_timeout ),
    .clear_i          ( clear          ),
    .expire_i         ( expire         ),
    .track_o          ( track          ),
    .block_o          ( block          ),
    .flush_o          ( flush          ),
    .trip_o           ( trip           ),
    .trip_id_o        ( trip_id        ),
    .irq_o            ( irq_o          ),
    .rst_req_o        ( rst_req_o      )
  );

  guard_cfg_regs i_cfg_regs (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .reg_addr_i       ( reg_addr_i     ),
    .reg_write_i      ( reg_write_i    ),
    .reg_wdata_i      ( reg_wdata_i    ),
    .reg_valid_i      ( reg_valid_i    ),
    .reg_rdata_o      ( reg_rdata_o    ),
    .reg_error_o      ( reg_error_o    ),
    .reg_ready_o      ( reg_ready_o    ),
    .trip_i           ( trip           ),
    .trip_id_i        ( trip_id        ),
    .tripped_i        ( irq_o          ),
    .query_addr_i     ( query_addr     ),
    .query_id_o       ( query_id       ),
    .enable_o         ( enable         ),
    .rst_on_timeout_o ( rst_on_timeout ),
    .clear_o          ( clear          ),
    .budget_o         ( budget         )
  );

endmodule

`default_nettype wire

//--- list.f
hw/guard_axi_pkg.sv
hw/guard_reg_pkg.sv
hw/guard_txn_table.sv
hw/guard_budget_timer.sv
hw/guard_ctrl_fsm.sv
hw/guard_cfg_regs.sv
hw/read_guard_top.sv
test/read_guard_assert.sv
test/tb_read_guard.sv

//--- test/read_guard_assert.sv
// Bound checks on the AR gating and interrupt outputs of read_guard_top
// Sampled on the rising edge, idle while reset is asserted
`default_nettype none

module read_guard_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic mgr_ar_valid_i,
  input logic mgr_ar_ready_i,
  input logic sub_ar_valid_i,
  input logic irq_i,
  input logic rst_req_i
);

  int unsigned assert_fails = 0;

  // Subordinate never sees an AR the manager did not issue
  a_ar_valid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sub_ar_valid_i |-> mgr_ar_valid_i)
    else begin
      assert_fails++;
      $error("sub AR valid high without manager AR valid");
    end

  a_rst_req_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rst_req_i |-> irq_i)
    else begin
      assert_fails++;
      $error("reset request high without interrupt");
    end

  // Tripped guard accepts no new reads
  a_irq_blocks_ar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_i |-> !mgr_ar_ready_i)
    else begin
      assert_fails++;
      $error("manager AR ready high while interrupt is raised");
    end

endmodule

bind read_guard_top read_guard_assert i_assert (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .mgr_ar_valid_i ( mgr_ar_valid_i ),
  .mgr_ar_ready_i ( mgr_ar_ready_o ),
  .sub_ar_valid_i ( sub_ar_valid_o ),
  .irq_i          ( irq_o          ),
  .rst_req_i      ( rst_req_o      )
);

`default_nettype wire

//--- test/tb_read_guard.sv
// Testbench for the read guard with manager, subordinate and register bus models
// The subordinate serves one burst at a time in arrival order, R ready is high while bursts are open
`default_nettype none

module tb_read_guard;
  import guard_axi_pkg::*;
  import guard_reg_pkg::*;

  logic      clk_i;
  logic      rst_n_i;
  id_t       mgr_ar_id_i;
  addr_t     mgr_ar_addr_i;
  len_t      mgr_ar_len_i;
  logic      mgr_ar_valid_i;
  logic      mgr_ar_ready_o;
  id_t       mgr_r_id_o;
  data_t     mgr_r_data_o;
  resp_t     mgr_r_resp_o;
  logic      mgr_r_last_o;
  logic      mgr_r_valid_o;
  logic      mgr_r_ready_i;
  id_t       sub_ar_id_o;
  addr_t     sub_ar_addr_o;
  len_t      sub_ar_len_o;
  logic      sub_ar_valid_o;
  logic      sub_ar_ready_i;
  id_t       sub_r_id_i;
  data_t     sub_r_data_i;
  resp_t     sub_r_resp_i;
  logic      sub_r_last_i;
  logic      sub_r_valid_i;
  logic      sub_r_ready_o;
  reg_addr_t reg_addr_i;
  logic      reg_write_i;
  reg_data_t reg_wdata_i;
  logic      reg_valid_i;
  reg_data_t reg_rdata_o;
  logic      reg_error_o;
  logic      reg_ready_o;
  logic      irq_o;
  logic      rst_req_o;

  int    seed = 32'h7f06_e7ac;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    bursts_done = 0;
  int    beat_cnt = 0;
  int    next_delay = 0;
  string cur_test = "reset";
  id_t   exp_id [$];
  addr_t exp_addr [$];
  len_t  exp_len [$];
  id_t   req_id [$];
  addr_t req_addr [$];
  len_t  req_len [$];
  int    req_dly [$];

  read_guard_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (20000) @(posedge clk_i);
    $display("Simulation stopped at the cycle limit");
    $display("Result: FAILED");
    $finish;
  end

  function automatic data_t beat_data(input addr_t addr, input int beat);
    return {addr + 32'(beat), ~addr ^ (32'h0101_0101 * 32'(beat))};
  endfunction

  // Response code alternates with address bit 2 and beat parity
  function automatic resp_t beat_resp(input addr_t addr, input int beat);
    return (addr[2] ^ beat[0]) ? RespSlvErr : RespOkay;
  endfunction

  // Last beat lands delay+beats edges after the AR handshake, its own cycle never trips
  function automatic logic expect_trip(input int budget, input int delay, input int beats);
    return (delay + beats - 1) > budget;
  endfunction

  task automatic check_data(input string what, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input resp_t exp, input resp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_reg(input string what, input reg_word_u exp, input reg_word_u act);
    checks++;
    if (act.raw !== exp.raw) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp.raw, act.raw);
    end
  endtask

  task automatic check_id(input string what, input id_t exp, input id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // Subordinate AR capture
  always @(negedge clk_i) begin
    if (rst_n_i && sub_ar_valid_o && sub_ar_ready_i) begin
      req_id.push_back(sub_ar_id_o);
      req_addr.push_back(sub_ar_addr_o);
      req_len.push_back(sub_ar_len_o);
      req_dly.push_back(next_delay);
    end
  end

  // Subordinate R responder
  initial begin
    id_t   rid;
    addr_t raddr;
    len_t  rlen;
    int    rdly;
    forever begin
      @(posedge clk_i);
      if (req_id.size() != 0) begin
        rid   = req_id.pop_front();
        raddr = req_addr.pop_front();
        rlen  = req_len.pop_front();
        rdly  = req_dly.pop_front();
        repeat (rdly) @(posedge clk_i);
        for (int j = 0; j <= int'(rlen); j++) begin
          #1;
          sub_r_valid_i = 1'b1;
          sub_r_id_i    = rid;
          sub_r_data_i  = beat_data(raddr, j);
          sub_r_resp_i  = beat_resp(raddr, j);
          sub_r_last_i  = (j == int'(rlen));
          @(posedge clk_i);
        end
        #1;
        sub_r_valid_i = 1'b0;
        sub_r_last_i  = 1'b0;
      end
    end
  end

  // Compares every R beat seen by the manager
  always @(negedge clk_i) begin
    if (rst_n_i && mgr_r_valid_o && mgr_r_ready_i) begin
      if (exp_id.size() == 0) begin
        errors++;
        $display("%s: R beat arrived with no open burst", cur_test);
      end else begin
        check_id("r id", exp_id[0], mgr_r_id_o);
        check_data("r data", beat_data(exp_addr[0], beat_cnt), mgr_r_data_o);
        check_resp("r resp", beat_resp(exp_addr[0], beat_cnt), mgr_r_resp_o);
        check_flag("r last", beat_cnt == int'(exp_len[0]), mgr_r_last_o);
        if (mgr_r_last_o) begin
          void'(exp_id.pop_front());
          void'(exp_addr.pop_front());
          void'(exp_len.pop_front());
          beat_cnt = 0;
          bursts_done++;
        end else begin
          beat_cnt++;
        end
      end
    end
  end

  task automatic issue_ar(input id_t id, input addr_t addr, input len_t len, input int dly,
                          input int limit);
    bit hs;
    int n;
    hs             = 1'b0;
    n              = 0;
    next_delay     = dly;
    mgr_ar_id_i    = id;
    mgr_ar_addr_i  = addr;
    mgr_ar_len_i   = len;
    mgr_ar_valid_i = 1'b1;
    while (!hs && n < limit) begin
      @(negedge clk_i);
      if (mgr_ar_ready_o) begin
        hs = 1'b1;
        exp_id.push_back(id);
        exp_addr.push_back(addr);
        exp_len.push_back(len);
      end
      @(posedge clk_i);
      #1;
      n++;
    end
    mgr_ar_valid_i = 1'b0;
    if (!hs) begin
      errors++;
      $display("%s: AR handshake did not happen within %0d cycles", cur_test, limit);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_id.size() != 0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_id.size() != 0) begin
      errors++;
      $display("%s: read data did not complete within %0d cycles", cur_test, limit);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic reg_access(input reg_addr_t addr, input logic write, input reg_data_t wdata,
                            output reg_word_u rdata, output logic err);
    logic ready;
    int   n;
    ready       = 1'b0;
    n           = 0;
    reg_addr_i  = addr;
    reg_write_i = write;
    reg_wdata_i = wdata;
    reg_valid_i = 1'b1;
    while (!ready && n < 20) begin
      @(negedge clk_i);
      ready = reg_ready_o;
      n++;
    end
    if (!ready) begin
      errors++;
      $display("%s: register bus gave no ready at %h", cur_test, addr);
    end
    rdata.raw = reg_rdata_o;
    err       = reg_error_o;
    @(posedge clk_i);
    #1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic write_reg(input string what, input reg_addr_t addr, input reg_data_t data,
                           input logic exp_err);
    reg_word_u rd;
    logic      err;
    reg_access(addr, 1'b1, data, rd, err);
    check_flag({what, " error"}, exp_err, err);
  endtask

  task automatic read_reg(input string what, input reg_addr_t addr, input reg_word_u exp);
    reg_word_u rd;
    logic      err;
    reg_access(addr, 1'b0, '0, rd, err);
    check_flag({what, " error"}, 1'b0, err);
    check_reg(what, exp, rd);
  endtask

  task automatic end_test(input int err_mark);
    tests++;
    $display("test %0d %s: %0d errors", tests, cur_test, errors - err_mark);
  endtask

  initial begin
    reg_word_u w;
    id_t       id;
    addr_t     addr;
    len_t      len;
    int        dly;
    int        n;
    int        err_mark;
    int        done_before;
    logic      err;
    mgr_ar_id_i    = '0;
    mgr_ar_addr_i  = '0;
    mgr_ar_len_i   = '0;
    mgr_ar_valid_i = 1'b0;
    mgr_r_ready_i  = 1'b1;
    sub_ar_ready_i = 1'b1;
    sub_r_id_i     = '0;
    sub_r_data_i   = '0;
    sub_r_resp_i   = RespOkay;
    sub_r_last_i   = 1'b0;
    sub_r_valid_i  = 1'b0;
    reg_addr_i     = '0;
    reg_write_i    = 1'b0;
    reg_wdata_i    = '0;
    reg_valid_i    = 1'b0;
    rst_n_i        = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    cur_test = "bypass";
    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      id   = id_t'($random(seed));
      addr = $random(seed);
      len  = len_t'($random(seed) & 3);
      dly  = $random(seed) & 7;
      issue_ar(id, addr, len, dly, 20);
      wait_drain(100);
      check_flag("irq", 1'b0, irq_o);
      check_flag("rst_req", 1'b0, rst_req_o);
    end
    // R ready passes straight to the subordinate
    mgr_r_ready_i = 1'b0;
    @(negedge clk_i);
    check_flag("r ready low", 1'b0, sub_r_ready_o);
    @(posedge clk_i);
    #1;
    mgr_r_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("r ready high", 1'b1, sub_r_ready_o);
    @(posedge clk_i);
    #1;
    end_test(err_mark);

    cur_test = "registers";
    err_mark = errors;
    w.raw = '0;
    w.budget.value = 16'h1234;
    write_reg("budget write", RegBudget, w.raw, 1'b0);
    read_reg("budget", RegBudget, w);
    w.raw = '0;
    w.ctrl.rst_on_timeout = 1'b1;
    write_reg("ctrl write", RegCtrl, w.raw, 1'b0);
    read_reg("ctrl", RegCtrl, w);
    w.raw = '0;
    read_reg("status", RegStatus, w);
    reg_access(32'h10, 1'b0, '0, w, err);
    check_flag("unmapped error", 1'b1, err);
    write_reg("status write", RegStatus, 32'h1, 1'b1);
    write_reg("ctrl restore", RegCtrl, 32'h0, 1'b0);
    end_test(err_mark);

    cur_test = "monitor";
    err_mark = errors;
    w.raw = '0;
    w.budget.value = 16'd40;
    write_reg("budget", RegBudget, w.raw, 1'b0);
    w.raw = '0;
    w.ctrl.enable = 1'b1;
    write_reg("enable", RegCtrl, w.raw, 1'b0);
    for (int i = 0; i < 4; i++) begin
      id   = id_t'($random(seed));
      addr = $random(seed);
      len  = len_t'($random(seed) & 3);
      dly  = $random(seed) & 15;
      issue_ar(id, addr, len, dly, 20);
      wait_drain(100);
      check_flag("irq", expect_trip(40, dly, int'(len) + 1), irq_o);
    end
    end_test(err_mark);

    cur_test = "timeout";
    err_mark = errors;
    w.raw = '0;
    w.budget.value = 16'd20;
    write_reg("budget", RegBudget, w.raw, 1'b0);
    w.raw = '0;
    w.ctrl.enable = 1'b1;
    w.ctrl.rst_on_timeout = 1'b1;
    write_reg("enable", RegCtrl, w.raw, 1'b0);
    addr = $random(seed);
    dly  = 30;
    issue_ar(2'd3, addr, 8'd1, dly, 20);
    n = 0;
    @(negedge clk_i);
    while (!irq_o && n < 40) begin
      @(posedge clk_i);
      n++;
      @(negedge clk_i);
    end
    check_flag("irq", expect_trip(20, dly, 2), irq_o);
    check_flag("irq latency", 1'b1, n == 21);
    check_flag("rst_req", 1'b1, rst_req_o);
    @(posedge clk_i);
    #1;
    w.raw = '0;
    w.status.tripped = 1'b1;
    w.status.offending_id = 2'd3;
    read_reg("status", RegStatus, w);
    w.raw = addr;
    read_reg("offending addr", RegAddr, w);
    mgr_ar_id_i    = 2'd0;
    mgr_ar_valid_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("ar ready blocked", 1'b0, mgr_ar_ready_o);
      check_flag("sub ar valid blocked", 1'b0, sub_ar_valid_o);
      @(posedge clk_i);
      #1;
    end
    mgr_ar_valid_i = 1'b0;
    wait_drain(100);
    end_test(err_mark);

    cur_test = "clear";
    err_mark = errors;
    w.raw = '0;
    w.ctrl.enable = 1'b1;
    w.ctrl.clear = 1'b1;
    write_reg("clear", RegCtrl, w.raw, 1'b0);
    @(negedge clk_i);
    check_flag("irq after clear", 1'b0, irq_o);
    check_flag("rst_req after clear", 1'b0, rst_req_o);
    @(posedge clk_i);
    #1;
    addr = $random(seed);
    issue_ar(2'd3, addr, 8'd3, 5, 20);
    wait_drain(100);
    check_flag("irq", 1'b0, irq_o);
    end_test(err_mark);

    cur_test = "same id stall";
    err_mark = errors;
    w.raw = '0;
    w.budget.value = 16'd100;
    write_reg("budget", RegBudget, w.raw, 1'b0);
    issue_ar(2'd1, 32'h1000, 8'd1, 20, 20);
    issue_ar(2'd2, 32'h2000, 8'd0, 0, 5);
    done_before    = bursts_done;
    mgr_ar_id_i    = 2'd1;
    mgr_ar_addr_i  = 32'h3000;
    mgr_ar_len_i   = 8'd0;
    mgr_ar_valid_i = 1'b1;
    @(negedge clk_i);
    check_flag("busy id stalled", 1'b0, mgr_ar_ready_o);
    @(posedge clk_i);
    #1;
    issue_ar(2'd1, 32'h3000, 8'd0, 0, 100);
    check_flag("stall held until last beat", 1'b1, bursts_done > done_before);
    wait_drain(100);
    check_flag("irq", 1'b0, irq_o);
    end_test(err_mark);

    errors = errors + i_dut.i_assert.assert_fails;
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
